// File: flist.f
verilog/dram_bridge_pkg.sv
verilog/sync_fifo.sv
verilog/rr_arbiter.sv
verilog/dram_tx.sv
verilog/dram_rx.sv
verilog/cache_to_dram_bridge.sv
verilog/test_dram.sv
verilog/cache_dram_top.sv
tests/tb_cache_dram.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_cache_dram
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: tests/tb_cache_dram.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cache_dram
  import dram_bridge_pkg::*;
();

  localparam int          clk_period_c = 4;
  localparam logic [31:0] seed_c       = 32'hb41f;
  // byte offset of a block inside a cache, and blocks per cache
  localparam int blk_off_c  = $clog2(block_words_c * data_width_c / 8);
  localparam int blk_bits_c = bank_addr_width_c - blk_off_c;
  localparam int num_blk_c  = 1 << blk_bits_c;
  localparam int stall_ops_c = 6;
  localparam int gap_ops_c   = 6;
  localparam int mix_ops_c   = 40;
  localparam int total_ops_c = 2 + 2 * num_cache_c + 2 * stall_ops_c * num_cache_c
                             + 2 * gap_ops_c * num_cache_c + mix_ops_c * num_cache_c;
  localparam int limit_cycles_c = 64 + 200 * total_ops_c;

  logic                                    core_clk;
  logic                                    core_reset;
  logic [num_cache_c-1:0]                  dma_pkt_v;
  logic [num_cache_c-1:0]                  dma_pkt_write;
  logic [num_cache_c-1:0][addr_width_c-1:0] dma_pkt_addr;
  logic [num_cache_c-1:0]                  dma_pkt_yumi;
  logic [num_cache_c-1:0][data_width_c-1:0] dma_data_out;
  logic [num_cache_c-1:0]                  dma_data_v_out;
  logic [num_cache_c-1:0]                  dma_data_ready;
  logic [num_cache_c-1:0][data_width_c-1:0] dma_data_in;
  logic [num_cache_c-1:0]                  dma_data_v_in;
  logic [num_cache_c-1:0]                  dma_data_yumi;

  int                     phase_id;
  int                     phase_seq;
  logic [num_cache_c-1:0] lanes_done;

  cache_dram_top dut0 (
    .core_clk_i       (core_clk),
    .core_reset_i     (core_reset),
    .dma_pkt_v_i      (dma_pkt_v),
    .dma_pkt_write_i  (dma_pkt_write),
    .dma_pkt_addr_i   (dma_pkt_addr),
    .dma_pkt_yumi_o   (dma_pkt_yumi),
    .dma_data_o       (dma_data_out),
    .dma_data_v_o     (dma_data_v_out),
    .dma_data_ready_i (dma_data_ready),
    .dma_data_i       (dma_data_in),
    .dma_data_v_i     (dma_data_v_in),
    .dma_data_yumi_o  (dma_data_yumi)
  );

  initial begin
    core_clk = 1'b0;
    forever #(clk_period_c / 2) core_clk = ~core_clk;
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // each cache gets its own point in the same sequence
  function automatic logic [31:0] lane_seed(input int lane);
    logic [31:0] s;
    s = seed_c;
    for (int i = 0; i < lane * 97; i++) begin
      s = lfsr_step(s);
    end
    return s;
  endfunction

  function automatic logic [addr_width_c-1:0] block_addr(input int blk);
    logic [addr_width_c-1:0] a;
    a = '0;
    a[blk_off_c +: blk_bits_c] = blk[blk_bits_c-1:0];
    return a;
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
      $display("Regression failed");
      $fatal(1, "value mismatch");
    end
  endtask

  for (genvar c = 0; c < num_cache_c; c++) begin : lane
    logic                    pkt_v;
    logic                    pkt_write;
    logic [addr_width_c-1:0] pkt_addr;
    logic                    data_ready;
    logic [data_width_c-1:0] wb_data;
    logic                    wb_v;
    logic [31:0]             rng;
    int                      done_seq;
    // reference copy of this cache's blocks
    logic [data_width_c-1:0] ref_blk [num_blk_c][block_words_c];
    bit                      written [num_blk_c];

    assign dma_pkt_v[c]      = pkt_v;
    assign dma_pkt_write[c]  = pkt_write;
    assign dma_pkt_addr[c]   = pkt_addr;
    assign dma_data_ready[c] = data_ready;
    assign dma_data_in[c]    = wb_data;
    assign dma_data_v_in[c]  = wb_v;
    assign lanes_done[c]     = (done_seq == phase_seq);

    function automatic logic rand_bit();
      rng = lfsr_step(rng);
      return rng[0];
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
        r = {r[30:0], rand_bit()};
      end
      return r;
    endfunction

    // starts and ends 1 ns after a rising edge
    task automatic write_block(input int blk, input bit gaps, input string name);
      int sent;
      bit pkt_done;
      for (int i = 0; i < block_words_c; i++) begin
        ref_blk[blk][i] = rand_bits(data_width_c);
      end
      written[blk] = 1'b1;
      sent      = 0;
      pkt_done  = 1'b0;
      pkt_v     = 1'b1;
      pkt_write = 1'b1;
      pkt_addr  = block_addr(blk);
      while (!pkt_done || sent < block_words_c) begin
        if (sent < block_words_c) begin
          wb_data = ref_blk[blk][sent];
          wb_v    = gaps ? rand_bit() : 1'b1;
        end else begin
          wb_v = 1'b0;
        end
        #2;
        // no fill is outstanding during a write-back
        check(name, '0, 32'(dma_data_v_out[c]));
        if (dma_pkt_yumi[c]) begin
          check(name, 32'd1, 32'(pkt_v));
          pkt_done = 1'b1;
        end
        if (dma_data_yumi[c]) begin
          check(name, 32'd1, 32'(wb_v));
          sent++;
        end
        @(posedge core_clk);
        #1;
        if (pkt_done) begin
          pkt_v = 1'b0;
        end
      end
      wb_v = 1'b0;
    endtask

    task automatic read_block(input int blk, input bit stalls, input string name);
      int got;
      bit pkt_done;
      got       = 0;
      pkt_done  = 1'b0;
      pkt_v     = 1'b1;
      pkt_write = 1'b0;
      pkt_addr  = block_addr(blk);
      while (got < block_words_c) begin
        data_ready = stalls ? rand_bit() : 1'b1;
        #2;
        if (dma_pkt_yumi[c]) begin
          check(name, 32'd1, 32'(pkt_v));
          pkt_done = 1'b1;
        end
        // low half of each dram word is the earlier cache word
        if (dma_data_v_out[c] && data_ready) begin
          check(name, ref_blk[blk][got], dma_data_out[c]);
          got++;
        end
        @(posedge core_clk);
        #1;
        if (pkt_done) begin
          pkt_v = 1'b0;
        end
      end
      data_ready = 1'b0;
      check(name, 32'd1, 32'(pkt_done));
    endtask

    initial begin
      int seen;
      int blk;
      pkt_v      = 1'b0;
      pkt_write  = 1'b0;
      pkt_addr   = '0;
      data_ready = 1'b0;
      wb_data    = '0;
      wb_v       = 1'b0;
      rng        = lane_seed(c);
      done_seq   = 0;
      seen       = 0;
      for (int b = 0; b < num_blk_c; b++) begin
        written[b] = 1'b0;
      end
      forever begin
        wait (phase_seq != seen);
        seen = phase_seq;
        case (phase_id)
          1: begin
            if (c == 0) begin
              write_block(3, 1'b0, "single_cache");
              read_block(3, 1'b0, "single_cache");
            end
          end
          // same block in every cache at once
          2: begin
            write_block(7, 1'b0, "all_caches");
            read_block(7, 1'b0, "all_caches");
          end
          3: begin
            repeat (stall_ops_c) begin
              blk = int'(rand_bits(blk_bits_c));
              write_block(blk, 1'b0, "fill_stall");
              read_block(blk, 1'b1, "fill_stall");
            end
          end
          4: begin
            repeat (gap_ops_c) begin
              blk = int'(rand_bits(blk_bits_c));
              write_block(blk, 1'b1, "write_gap");
              read_block(blk, 1'b0, "write_gap");
            end
          end
          5: begin
            repeat (mix_ops_c) begin
              blk = int'(rand_bits(blk_bits_c));
              if (rand_bit() && written[blk]) begin
                read_block(blk, 1'b1, "random_mix");
              end else begin
                write_block(blk, 1'b1, "random_mix");
              end
            end
          end
          default: begin
          end
        endcase
        done_seq = seen;
      end
    end
  end

  // called 1 ns after an edge, returns at the same point of a later cycle
  task automatic run_phase(input int id);
    phase_id  = id;
    phase_seq = phase_seq + 1;
    @(posedge core_clk);
    wait (&lanes_done);
    @(posedge core_clk);
    #1;
  endtask

  initial begin
    #(limit_cycles_c * clk_period_c);
    $display("timeout: the DMA operations did not finish within %0d cycles", limit_cycles_c);
    $display("Regression failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    core_reset = 1'b1;
    phase_id   = 0;
    phase_seq  = 0;
    repeat (16) @(posedge core_clk);
    #1;
    core_reset = 1'b0;
    // no input is valid yet, so the cache side stays quiet
    repeat (16) begin
      #2;
      check("reset_idle", '0, 32'({dma_pkt_yumi, dma_data_v_out, dma_data_yumi}));
      @(posedge core_clk);
      #1;
    end
    run_phase(1);
    run_phase(2);
    run_phase(3);
    run_phase(4);
    run_phase(5);
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/cache_dram_top.sv
`timescale 1ns/1ns
`default_nettype none

module cache_dram_top
  import dram_bridge_pkg::*;
#(
  parameter int num_cache_p       = num_cache_c,
  parameter int addr_width_p      = addr_width_c,
  parameter int data_width_p      = data_width_c,
  parameter int dram_data_width_p = dram_data_width_c,
  parameter int block_words_p     = block_words_c,
  parameter int bank_addr_width_p = bank_addr_width_c,
  parameter int dram_addr_width_p = dram_addr_width_c,
  parameter int num_req_p         = num_req_c,
  parameter int dram_words_p      = dram_words_c
) (
  input  wire                                      core_clk_i,
  input  wire                                      core_reset_i,
  input  wire  [num_cache_p-1:0]                   dma_pkt_v_i,
  input  wire  [num_cache_p-1:0]                   dma_pkt_write_i,
  input  wire  [num_cache_p-1:0][addr_width_p-1:0] dma_pkt_addr_i,
  output logic [num_cache_p-1:0]                   dma_pkt_yumi_o,
  output logic [num_cache_p-1:0][data_width_p-1:0] dma_data_o,
  output logic [num_cache_p-1:0]                   dma_data_v_o,
  input  wire  [num_cache_p-1:0]                   dma_data_ready_i,
  input  wire  [num_cache_p-1:0][data_width_p-1:0] dma_data_i,
  input  wire  [num_cache_p-1:0]                   dma_data_v_i,
  output logic [num_cache_p-1:0]                   dma_data_yumi_o
);

  logic                         dram_req_v;
  logic                         dram_write_not_read;
  logic [dram_addr_width_p-1:0] dram_ch_addr;
  logic                         dram_req_yumi;
  logic                         dram_data_v;
  logic [dram_data_width_p-1:0] dram_data;
  logic                         dram_data_yumi;
  logic                         rd_data_v;
  logic [dram_data_width_p-1:0] rd_data;
  logic [dram_addr_width_p-1:0] rd_ch_addr;

  cache_to_dram_bridge #(
    .num_cache_p       (num_cache_p),
    .addr_width_p      (addr_width_p),
    .data_width_p      (data_width_p),
    .dram_data_width_p (dram_data_width_p),
    .block_words_p     (block_words_p),
    .bank_addr_width_p (bank_addr_width_p),
    .dram_addr_width_p (dram_addr_width_p),
    .num_req_p         (num_req_p)
  ) bridge0 (
    .core_clk_i            (core_clk_i),
    .core_reset_i          (core_reset_i),
    .dma_pkt_v_i           (dma_pkt_v_i),
    .dma_pkt_write_i       (dma_pkt_write_i),
    .dma_pkt_addr_i        (dma_pkt_addr_i),
    .dma_pkt_yumi_o        (dma_pkt_yumi_o),
    .dma_data_o            (dma_data_o),
    .dma_data_v_o          (dma_data_v_o),
    .dma_data_ready_i      (dma_data_ready_i),
    .dma_data_i            (dma_data_i),
    .dma_data_v_i          (dma_data_v_i),
    .dma_data_yumi_o       (dma_data_yumi_o),
    .dram_req_v_o          (dram_req_v),
    .dram_write_not_read_o (dram_write_not_read),
    .dram_ch_addr_o        (dram_ch_addr),
    .dram_req_yumi_i       (dram_req_yumi),
    .dram_data_v_o         (dram_data_v),
    .dram_data_o           (dram_data),
    .dram_data_yumi_i      (dram_data_yumi),
    .rd_data_v_i           (rd_data_v),
    .rd_data_i             (rd_data),
    .rd_ch_addr_i          (rd_ch_addr)
  );

  test_dram #(
    .dram_addr_width_p (dram_addr_width_p),
    .dram_data_width_p (dram_data_width_p),
    .dram_words_p      (dram_words_p)
  ) dram0 (
    .core_clk_i            (core_clk_i),
    .core_reset_i          (core_reset_i),
    .dram_req_v_i          (dram_req_v),
    .dram_write_not_read_i (dram_write_not_read),
    .dram_ch_addr_i        (dram_ch_addr),
    .dram_req_yumi_o       (dram_req_yumi),
    .dram_data_v_i         (dram_data_v),
    .dram_data_i           (dram_data),
    .dram_data_yumi_o      (dram_data_yumi),
    .rd_data_v_o           (rd_data_v),
    .rd_data_o             (rd_data),
    .rd_ch_addr_o          (rd_ch_addr)
  );

endmodule

`default_nettype wire

// File: verilog/test_dram.sv
`timescale 1ns/1ns
`default_nettype none

module test_dram
  import dram_bridge_pkg::*;
#(
  parameter int  dram_addr_width_p = dram_addr_width_c,
  parameter int  dram_data_width_p = dram_data_width_c,
  parameter int  dram_words_p      = dram_words_c,
  localparam int lg_words_lp       = $clog2(dram_words_p),
  localparam int byte_off_lp       = $clog2(dram_data_width_p / 8)
) (
  input  wire                          core_clk_i,
  input  wire                          core_reset_i,
  input  wire                          dram_req_v_i,
  input  wire                          dram_write_not_read_i,
  input  wire  [dram_addr_width_p-1:0] dram_ch_addr_i,
  output logic                         dram_req_yumi_o,
  input  wire                          dram_data_v_i,
  input  wire  [dram_data_width_p-1:0] dram_data_i,
  output logic                         dram_data_yumi_o,
  output logic                         rd_data_v_o,
  output logic [dram_data_width_p-1:0] rd_data_o,
  output logic [dram_addr_width_p-1:0] rd_ch_addr_o
);

  logic [dram_data_width_p-1:0] mem_r [dram_words_p];
  logic [lg_words_lp-1:0]       word_addr;
  logic                         write_go;
  logic                         read_go;

  // byte offset dropped
  assign word_addr = dram_ch_addr_i[byte_off_lp +: lg_words_lp];

  // a write waits for its data word, a read goes at once
  assign write_go = dram_req_v_i & dram_write_not_read_i & dram_data_v_i;
  assign read_go  = dram_req_v_i & ~dram_write_not_read_i;

  assign dram_req_yumi_o  = write_go | read_go;
  assign dram_data_yumi_o = write_go;

  always_ff @(posedge core_clk_i) begin
    if (write_go) begin
      mem_r[word_addr] <= dram_data_i;
    end
  end

  // read data returns with its own address
  always_ff @(posedge core_clk_i) begin
    if (read_go) begin
      rd_data_o    <= mem_r[word_addr];
      rd_ch_addr_o <= dram_ch_addr_i;
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (core_reset_i) begin
      rd_data_v_o <= 1'b0;
    end else begin
      rd_data_v_o <= read_go;
    end
  end

endmodule

`default_nettype wire

// File: verilog/cache_to_dram_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module cache_to_dram_bridge
  import dram_bridge_pkg::*;
#(
  parameter int  num_cache_p       = num_cache_c,
  parameter int  addr_width_p      = addr_width_c,
  parameter int  data_width_p      = data_width_c,
  parameter int  dram_data_width_p = dram_data_width_c,
  parameter int  block_words_p     = block_words_c,
  parameter int  bank_addr_width_p = bank_addr_width_c,
  parameter int  dram_addr_width_p = dram_addr_width_c,
  parameter int  num_req_p         = block_words_p * data_width_p / dram_data_width_p,
  localparam int lg_num_cache_lp   = (num_cache_p > 1) ? $clog2(num_cache_p) : 1,
  localparam int lg_num_req_lp     = (num_req_p > 1) ? $clog2(num_req_p) : 1,
  localparam int byte_off_lp       = $clog2(dram_data_width_p / 8),
  localparam int blk_bits_lp       = bank_addr_width_p - byte_off_lp - lg_num_req_lp,
  localparam int pkt_width_lp      = 1 + addr_width_p
) (
  input  wire                                      core_clk_i,
  input  wire                                      core_reset_i,
  // cache dma packets
  input  wire  [num_cache_p-1:0]                   dma_pkt_v_i,
  input  wire  [num_cache_p-1:0]                   dma_pkt_write_i,
  input  wire  [num_cache_p-1:0][addr_width_p-1:0] dma_pkt_addr_i,
  output logic [num_cache_p-1:0]                   dma_pkt_yumi_o,
  // fill data
  output logic [num_cache_p-1:0][data_width_p-1:0] dma_data_o,
  output logic [num_cache_p-1:0]                   dma_data_v_o,
  input  wire  [num_cache_p-1:0]                   dma_data_ready_i,
  // write-back data
  input  wire  [num_cache_p-1:0][data_width_p-1:0] dma_data_i,
  input  wire  [num_cache_p-1:0]                   dma_data_v_i,
  output logic [num_cache_p-1:0]                   dma_data_yumi_o,
  // dram request
  output logic                                     dram_req_v_o,
  output logic                                     dram_write_not_read_o,
  output logic [dram_addr_width_p-1:0]             dram_ch_addr_o,
  input  wire                                      dram_req_yumi_i,
  // dram write data
  output logic                                     dram_data_v_o,
  output logic [dram_data_width_p-1:0]             dram_data_o,
  input  wire                                      dram_data_yumi_i,
  // dram read data, valid only
  input  wire                                      rd_data_v_i,
  input  wire  [dram_data_width_p-1:0]             rd_data_i,
  input  wire  [dram_addr_width_p-1:0]             rd_ch_addr_i
);

  localparam int lg_req_depth_lp = $clog2(4 * num_cache_p);

  logic [num_cache_p-1:0][pkt_width_lp-1:0] pkt_li;
  logic                       rr_v_lo;
  logic                       rr_yumi_li;
  logic [pkt_width_lp-1:0]    rr_pkt_lo;
  logic [lg_num_cache_lp-1:0] rr_tag_lo;

  logic                       write_r;
  logic                       write_n;
  logic [addr_width_p-1:0]    addr_r;
  logic [addr_width_p-1:0]    addr_n;
  logic [lg_num_cache_lp-1:0] tag_r;
  logic [lg_num_cache_lp-1:0] tag_n;

  logic [lg_num_req_lp-1:0]   count_r;
  logic                       counter_up;
  logic                       counter_clear;

  logic                       req_enq;
  logic                       req_full;
  logic [dram_addr_width_p-1:0] req_addr;
  logic                       tx_v_li;
  logic                       tx_ready_lo;

  always_comb begin
    for (int i = 0; i < num_cache_p; i++) begin
      pkt_li[i] = {dma_pkt_write_i[i], dma_pkt_addr_i[i]};
    end
  end

  rr_arbiter #(
    .num_in_p (num_cache_p),
    .width_p  (pkt_width_lp)
  ) rr0 (
    .core_clk_i   (core_clk_i),
    .core_reset_i (core_reset_i),
    .v_i          (dma_pkt_v_i),
    .data_i       (pkt_li),
    .yumi_o       (dma_pkt_yumi_o),
    .v_o          (rr_v_lo),
    .data_o       (rr_pkt_lo),
    .tag_o        (rr_tag_lo),
    .yumi_i       (rr_yumi_li)
  );

  // beat 0 takes the packet, later beats replay the held one
  always_comb begin
    counter_up    = 1'b0;
    counter_clear = 1'b0;
    rr_yumi_li    = 1'b0;
    req_enq       = 1'b0;
    tx_v_li       = 1'b0;
    write_n       = write_r;
    addr_n        = addr_r;
    tag_n         = tag_r;
    if (count_r == '0) begin
      if (rr_v_lo & ~req_full & (~rr_pkt_lo[addr_width_p] | tx_ready_lo)) begin
        counter_up = (num_req_p > 1);
        rr_yumi_li = 1'b1;
        req_enq    = 1'b1;
        tx_v_li    = rr_pkt_lo[addr_width_p];
        write_n    = rr_pkt_lo[addr_width_p];
        addr_n     = rr_pkt_lo[addr_width_p-1:0];
        tag_n      = rr_tag_lo;
      end
    end else if (~req_full & (~write_r | tx_ready_lo)) begin
      req_enq = 1'b1;
      tx_v_li = write_r;
      if (count_r == lg_num_req_lp'(num_req_p - 1)) begin
        counter_clear = 1'b1;
      end else begin
        counter_up = 1'b1;
      end
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (core_reset_i) begin
      count_r <= '0;
      write_r <= 1'b0;
    end else begin
      write_r <= write_n;
      if (counter_clear) begin
        count_r <= '0;
      end else if (counter_up) begin
        count_r <= count_r + 1'b1;
      end
    end
  end

  always_ff @(posedge core_clk_i) begin
    addr_r <= addr_n;
    tag_r  <= tag_n;
  end

  // {cache index, block address, beat, byte offset}
  always_comb begin
    req_addr = '0;
    req_addr[dram_addr_width_p-1 -: lg_num_cache_lp] = tag_n;
    req_addr[bank_addr_width_p-1 -: blk_bits_lp] = addr_n[bank_addr_width_p-1 -: blk_bits_lp];
    req_addr[byte_off_lp +: lg_num_req_lp] = count_r;
  end

  sync_fifo #(
    .width_p    (1 + dram_addr_width_p),
    .lg_depth_p (lg_req_depth_lp)
  ) req_q (
    .core_clk_i   (core_clk_i),
    .core_reset_i (core_reset_i),
    .enq_i        (req_enq),
    .data_i       ({write_n, req_addr}),
    .full_o       (req_full),
    .deq_i        (dram_req_yumi_i),
    .data_o       ({dram_write_not_read_o, dram_ch_addr_o}),
    .valid_o      (dram_req_v_o)
  );

  dram_tx #(
    .num_cache_p       (num_cache_p),
    .data_width_p      (data_width_p),
    .dram_data_width_p (dram_data_width_p)
  ) tx0 (
    .core_clk_i       (core_clk_i),
    .core_reset_i     (core_reset_i),
    .v_i              (tx_v_li),
    .tag_i            (tag_n),
    .ready_o          (tx_ready_lo),
    .dma_data_i       (dma_data_i),
    .dma_data_v_i     (dma_data_v_i),
    .dma_data_yumi_o  (dma_data_yumi_o),
    .dram_data_v_o    (dram_data_v_o),
    .dram_data_o      (dram_data_o),
    .dram_data_yumi_i (dram_data_yumi_i)
  );

  dram_rx #(
    .num_cache_p       (num_cache_p),
    .data_width_p      (data_width_p),
    .dram_data_width_p (dram_data_width_p),
    .dram_addr_width_p (dram_addr_width_p),
    .num_req_p         (num_req_p)
  ) rx0 (
    .core_clk_i       (core_clk_i),
    .core_reset_i     (core_reset_i),
    .dram_data_v_i    (rd_data_v_i),
    .dram_data_i      (rd_data_i),
    .dram_ch_addr_i   (rd_ch_addr_i),
    .dma_data_o       (dma_data_o),
    .dma_data_v_o     (dma_data_v_o),
    .dma_data_ready_i (dma_data_ready_i)
  );

endmodule

`default_nettype wire

// File: verilog/dram_rx.sv
`timescale 1ns/1ns
`default_nettype none

module dram_rx
  import dram_bridge_pkg::*;
#(
  parameter int  num_cache_p       = num_cache_c,
  parameter int  data_width_p      = data_width_c,
  parameter int  dram_data_width_p = dram_data_width_c,
  parameter int  dram_addr_width_p = dram_addr_width_c,
  parameter int  num_req_p         = num_req_c,
  localparam int lg_num_cache_lp   = (num_cache_p > 1) ? $clog2(num_cache_p) : 1,
  localparam int lg_num_req_lp     = (num_req_p > 1) ? $clog2(num_req_p) : 1
) (
  input  wire                                      core_clk_i,
  input  wire                                      core_reset_i,
  input  wire                                      dram_data_v_i,
  input  wire  [dram_data_width_p-1:0]             dram_data_i,
  input  wire  [dram_addr_width_p-1:0]             dram_ch_addr_i,
  output logic [num_cache_p-1:0][data_width_p-1:0] dma_data_o,
  output logic [num_cache_p-1:0]                   dma_data_v_o,
  input  wire  [num_cache_p-1:0]                   dma_data_ready_i
);

  logic [lg_num_cache_lp-1:0] rx_idx;
  logic [num_cache_p-1:0]     q_full;

  // owner cache sits in the top address bits
  assign rx_idx = dram_ch_addr_i[dram_addr_width_p-1 -: lg_num_cache_lp];

  for (genvar i = 0; i < num_cache_p; i++) begin : lane
    logic                         q_v;
    logic                         q_deq;
    logic [dram_data_width_p-1:0] head_word;
    logic                         phase_r;

    // one block deep
    sync_fifo #(
      .width_p    (dram_data_width_p),
      .lg_depth_p (lg_num_req_lp)
    ) rx_q (
      .core_clk_i   (core_clk_i),
      .core_reset_i (core_reset_i),
      .enq_i        (dram_data_v_i & (rx_idx == lg_num_cache_lp'(i))),
      .data_i       (dram_data_i),
      .full_o       (q_full[i]),
      .deq_i        (q_deq),
      .data_o       (head_word),
      .valid_o      (q_v)
    );

    // low half goes out first
    assign dma_data_o[i]   = phase_r ? head_word[dram_data_width_p-1 -: data_width_p]
                                     : head_word[data_width_p-1:0];
    assign dma_data_v_o[i] = q_v;
    assign q_deq           = q_v & dma_data_ready_i[i] & phase_r;

    always_ff @(posedge core_clk_i) begin
      if (core_reset_i) begin
        phase_r <= 1'b0;
      end else if (q_v & dma_data_ready_i[i]) begin
        phase_r <= ~phase_r;
      end
    end
  end

  // one outstanding fill per cache keeps every lane from overflowing
  fill_room_a: assert property (@(posedge core_clk_i) disable iff (core_reset_i)
    dram_data_v_i |-> !q_full[rx_idx])
    else $error("dram_rx: read data returned to a full cache queue");

endmodule

`default_nettype wire

// File: verilog/dram_tx.sv
`timescale 1ns/1ns
`default_nettype none

module dram_tx
  import dram_bridge_pkg::*;
#(
  parameter int  num_cache_p       = num_cache_c,
  parameter int  data_width_p      = data_width_c,
  parameter int  dram_data_width_p = dram_data_width_c,
  localparam int lg_num_cache_lp   = (num_cache_p > 1) ? $clog2(num_cache_p) : 1
) (
  input  wire                                      core_clk_i,
  input  wire                                      core_reset_i,
  input  wire                                      v_i,
  input  wire  [lg_num_cache_lp-1:0]               tag_i,
  output logic                                     ready_o,
  input  wire  [num_cache_p-1:0][data_width_p-1:0] dma_data_i,
  input  wire  [num_cache_p-1:0]                   dma_data_v_i,
  output logic [num_cache_p-1:0]                   dma_data_yumi_o,
  output logic                                     dram_data_v_o,
  output logic [dram_data_width_p-1:0]             dram_data_o,
  input  wire                                      dram_data_yumi_i
);

  // one block of beats in flight
  localparam int lg_tag_depth_lp = 2;

  logic                         tag_full;
  logic                         tag_v;
  logic [lg_num_cache_lp-1:0]   head_tag;
  logic                         out_full;
  logic                         phase_r;
  logic [data_width_p-1:0]      half_r;
  logic                         take;
  logic [dram_data_width_p-1:0] packed_word;

  sync_fifo #(
    .width_p    (lg_num_cache_lp),
    .lg_depth_p (lg_tag_depth_lp)
  ) tag_q (
    .core_clk_i   (core_clk_i),
    .core_reset_i (core_reset_i),
    .enq_i        (v_i),
    .data_i       (tag_i),
    .full_o       (tag_full),
    .deq_i        (take & phase_r),
    .data_o       (head_tag),
    .valid_o      (tag_v)
  );

  assign ready_o = ~tag_full;

  // second word needs room in the output queue
  assign take        = tag_v & dma_data_v_i[head_tag] & (~phase_r | ~out_full);
  // earlier word in the low half
  assign packed_word = {dma_data_i[head_tag], half_r};

  always_comb begin
    dma_data_yumi_o           = '0;
    dma_data_yumi_o[head_tag] = take;
  end

  always_ff @(posedge core_clk_i) begin
    if (core_reset_i) begin
      phase_r <= 1'b0;
    end else if (take) begin
      phase_r <= ~phase_r;
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (take & ~phase_r) begin
      half_r <= dma_data_i[head_tag];
    end
  end

  sync_fifo #(
    .width_p    (dram_data_width_p),
    .lg_depth_p (1)
  ) out_q (
    .core_clk_i   (core_clk_i),
    .core_reset_i (core_reset_i),
    .enq_i        (take & phase_r),
    .data_i       (packed_word),
    .full_o       (out_full),
    .deq_i        (dram_data_yumi_i),
    .data_o       (dram_data_o),
    .valid_o      (dram_data_v_o)
  );

endmodule

`default_nettype wire

// File: verilog/rr_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module rr_arbiter #(
  parameter int  num_in_p     = 2,
  parameter int  width_p      = 8,
  localparam int lg_num_in_lp = (num_in_p > 1) ? $clog2(num_in_p) : 1
) (
  input  wire                               core_clk_i,
  input  wire                               core_reset_i,
  input  wire  [num_in_p-1:0]               v_i,
  input  wire  [num_in_p-1:0][width_p-1:0]  data_i,
  output logic [num_in_p-1:0]               yumi_o,
  output logic                              v_o,
  output logic [width_p-1:0]                data_o,
  output logic [lg_num_in_lp-1:0]           tag_o,
  input  wire                               yumi_i
);

  // index of the last input that was granted
  logic [lg_num_in_lp-1:0] last_r;

  // scan downward so the nearest valid input after last_r wins
  always_comb begin
    int idx;
    v_o   = 1'b0;
    tag_o = last_r;
    for (int i = num_in_p; i >= 1; i--) begin
      idx = (int'(last_r) + i) % num_in_p;
      if (v_i[idx]) begin
        v_o   = 1'b1;
        tag_o = lg_num_in_lp'(idx);
      end
    end
  end

  assign data_o = data_i[tag_o];

  always_comb begin
    yumi_o        = '0;
    yumi_o[tag_o] = yumi_i;
  end

  // start at input 0 after reset
  always_ff @(posedge core_clk_i) begin
    if (core_reset_i) begin
      last_r <= lg_num_in_lp'(num_in_p - 1);
    end else if (yumi_i) begin
      last_r <= tag_o;
    end
  end

  grant_a: assert property (@(posedge core_clk_i) disable iff (core_reset_i)
    yumi_i |-> v_o) else $error("rr_arbiter: grant taken with no valid input");

endmodule

`default_nettype wire

// File: verilog/sync_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
  parameter int width_p    = 8,
  parameter int lg_depth_p = 2
) (
  input  wire                core_clk_i,
  input  wire                core_reset_i,
  input  wire                enq_i,
  input  wire  [width_p-1:0] data_i,
  output logic               full_o,
  input  wire                deq_i,
  output logic [width_p-1:0] data_o,
  output logic               valid_o
);

  localparam int depth_lp = 1 << lg_depth_p;

  logic [width_p-1:0]    mem_r [depth_lp];
  logic [lg_depth_p-1:0] wptr_r;
  logic [lg_depth_p-1:0] rptr_r;
  logic [lg_depth_p:0]   count_r;

  always_ff @(posedge core_clk_i) begin
    if (enq_i) begin
      mem_r[wptr_r] <= data_i;
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (core_reset_i) begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      count_r <= '0;
    end else begin
      if (enq_i) begin
        wptr_r <= wptr_r + 1'b1;
      end
      if (deq_i) begin
        rptr_r <= rptr_r + 1'b1;
      end
      case ({enq_i, deq_i})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  assign full_o  = (count_r == (lg_depth_p+1)'(depth_lp));
  assign valid_o = (count_r != '0);
  assign data_o  = mem_r[rptr_r];

  // callers must check full and valid themselves
  overflow_a: assert property (@(posedge core_clk_i) disable iff (core_reset_i)
    enq_i |-> !full_o) else $error("sync_fifo: enqueue while full");
  underflow_a: assert property (@(posedge core_clk_i) disable iff (core_reset_i)
    deq_i |-> valid_o) else $error("sync_fifo: dequeue while empty");

endmodule

`default_nettype wire

// File: verilog/dram_bridge_pkg.sv
`default_nettype none

package dram_bridge_pkg;

  // cache side
  parameter int num_cache_c       = 4;
  parameter int data_width_c      = 32;
  parameter int block_words_c     = 8;
  parameter int addr_width_c      = 32;
  // 1 KiB used per cache
  parameter int bank_addr_width_c = 10;

  // dram channel
  parameter int dram_data_width_c = 64;
  parameter int dram_addr_width_c = 12;
  parameter int dram_words_c      = 512;

  // dram words per cache block
  parameter int num_req_c = block_words_c * data_width_c / dram_data_width_c;

endpackage

`default_nettype wire
